//--- build.f
hdl/xt_mem_pkg.sv
hdl/sdram_pkg.sv
hdl/ems_address_map.sv
hdl/ram_bus_port.sv
hdl/sdram_controller.sv
hdl/xt_ram_top.sv
verif/sdram_model.sv
verif/tb_xt_ram.sv

//--- hdl/ems_address_map.sv
`timescale 1ns/1ps
// ---------------------------------------------------------------------
// Combinational decode of a CPU address into RAM select, BIOS write
// protect and the physical SDRAM byte address (EMS and Tandy remap)
// ---------------------------------------------------------------------
module ems_address_map (
    input  xt_mem_pkg::bus_addr_t  bus_addr,
    input  xt_mem_pkg::ems_map_t   ems,
    input  xt_mem_pkg::bios_ctrl_t bios,
    input  logic                   enable_sdram,
    output logic                   ram_select_n,
    output logic                   write_protect,
    output sdram_pkg::sdram_addr_u phys
);
    import xt_mem_pkg::*;

    logic [3:0] segment;
    logic       video_hole;
    logic       a000_hole;
    logic       tandy_select;

    assign segment = bus_addr[19:16];

    // B0000h belongs to video RAM, A0000h only when not enabled as RAM
    assign video_hole = (segment == SEG_B000);
    assign a000_hole  = (segment == SEG_A000) && !bios.enable_a000h;

    assign ram_select_n = ~(enable_sdram && !video_hole && !a000_hole);

    assign tandy_select = bios.tandy && (segment == SEG_F000);

    assign write_protect = (bios.protect[1] && (segment == SEG_F000))
                         || (bios.protect[0] && (bus_addr[19:14] == BLOCK_EC000));

    always_comb begin
        // Conventional space, bit 20 picks the separate Tandy BIOS area
        phys.linear = {1'b0, tandy_select, bus_addr};

        // Window 0 wins, so it is applied last
        for (int i = EMS_WINDOWS - 1; i >= 0; i--) begin
            if (ems.enable[i]) begin
                phys.linear = {1'b1, ems.page[i], bus_addr[13:0]};
            end
        end
    end

endmodule

//--- hdl/ram_bus_port.sv
`timescale 1ns/1ps
// ---------------------------------------------------------------------
// Bus side of the RAM path. A held read or write command becomes one
// request strobe to the SDRAM controller; ready is held low until the
// transfer is complete and the read byte is returned on data_bus_out
// ---------------------------------------------------------------------
module ram_bus_port (
    input  logic                   clock,
    input  logic                   reset,
    input  xt_mem_pkg::bus_cmd_t   cmd,
    input  logic                   ram_select_n,
    input  logic                   write_protect,
    input  sdram_pkg::sdram_addr_u phys,
    input  logic                   no_command_state,
    input  logic                   done,
    input  logic                   idle,
    input  logic [15:0]            read_data,
    output logic                   write_request,
    output logic                   read_request,
    output logic                   refresh_request,
    output sdram_pkg::sdram_addr_u access_addr,
    output logic [7:0]             write_data,
    output logic [7:0]             data_bus_out,
    output logic                   ready,
    output logic                   initialized
);
    typedef enum logic [1:0] {
        S_IDLE,
        S_REQUEST,
        S_WAIT,
        S_COMPLETE
    } state_t;

    state_t     state;
    logic       ram_command;
    logic       write_cycle;
    logic       prev_no_command;
    logic       refresh_pending;
    logic       grant;
    logic [7:0] read_byte;

    assign ram_command = ~ram_select_n & (~cmd.read_n | ~cmd.write_n);

    // A pending refresh goes first, the access strobes once idle again
    assign refresh_request = refresh_pending & idle;
    assign grant           = (state == S_REQUEST) & idle & ~refresh_pending;
    assign write_request   = grant & write_cycle;
    assign read_request    = grant & ~write_cycle;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            state           <= S_IDLE;
            write_cycle     <= 1'b0;
            prev_no_command <= 1'b0;
            refresh_pending <= 1'b0;
            initialized     <= 1'b0;
        end else begin
            prev_no_command <= no_command_state;
            refresh_pending <= (no_command_state & ~prev_no_command)
                             | (refresh_pending & ~idle);
            if (idle)
                initialized <= 1'b1;

            case (state)
                S_IDLE: begin
                    if (initialized && ram_command) begin
                        write_cycle <= ~cmd.write_n;
                        // Protected write finishes without touching SDRAM
                        if (!cmd.write_n && write_protect)
                            state <= S_COMPLETE;
                        else
                            state <= S_REQUEST;
                    end
                end
                S_REQUEST: begin
                    if (grant)
                        state <= S_WAIT;
                end
                S_WAIT: begin
                    if (done)
                        state <= S_COMPLETE;
                end
                S_COMPLETE: begin
                    if (!ram_command)
                        state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == S_IDLE) begin
            access_addr <= phys;
            write_data  <= cmd.write_data;
        end
        if (state == S_WAIT && done)
            read_byte <= access_addr.field.lane ? read_data[15:8] : read_data[7:0];
    end

    // Commands outside RAM are never held
    assign ready = ram_command ? (state == S_COMPLETE) : 1'b1;

    assign data_bus_out = (state == S_COMPLETE && ram_command && !cmd.read_n)
                        ? read_byte : 8'h00;

endmodule

//--- hdl/sdram_controller.sv
`timescale 1ns/1ps
// ---------------------------------------------------------------------
// Single-word SDRAM controller. Runs the power-up sequence, then serves
// refresh and byte read/write strobes one at a time, each access closed
// with auto-precharge. idle is high when a new strobe can be taken
// ---------------------------------------------------------------------
module sdram_controller (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   write_request,
    input  logic                   read_request,
    input  logic                   refresh_request,
    input  sdram_pkg::sdram_addr_u access_addr,
    input  logic [7:0]             write_data,
    input  logic [15:0]            dq_in,
    output logic [15:0]            read_data,
    output logic                   done,
    output logic                   idle,
    output sdram_pkg::sdram_pins_t pins
);
    import sdram_pkg::*;

    typedef enum logic [3:0] {
        S_INIT_WAIT,
        S_INIT_PRECHARGE,
        S_INIT_REFRESH,
        S_INIT_MODE,
        S_IDLE,
        S_REFRESH,
        S_ACTIVATE,
        S_READ,
        S_WRITE,
        S_RECOVER
    } state_t;

    state_t                 state;
    logic [COUNT_WIDTH-1:0] count;
    logic                   second_refresh;
    logic                   write_cycle;

    assign idle = (state == S_IDLE);

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            state          <= S_INIT_WAIT;
            count          <= COUNT_WIDTH'(INIT_WAIT_CYCLES - 1);
            second_refresh <= 1'b0;
            write_cycle    <= 1'b0;
            done           <= 1'b0;
            pins           <= '{address: '0, ba: '0, cke: 1'b0, cmd: NOP,
                                dq_out: '0, dq_oe: 1'b0, dqm: 2'b11};
        end else begin
            pins.cke   <= 1'b1;
            pins.cmd   <= NOP;
            pins.dq_oe <= 1'b0;
            done       <= 1'b0;
            if (count != '0)
                count <= count - 1'b1;

            case (state)
                S_INIT_WAIT: begin
                    if (count == '0) begin
                        // Precharge all banks via A10
                        pins.cmd     <= PRECHARGE;
                        pins.address <= 13'h0400;
                        count        <= COUNT_WIDTH'(T_RP - 1);
                        state        <= S_INIT_PRECHARGE;
                    end
                end
                S_INIT_PRECHARGE: begin
                    if (count == '0) begin
                        pins.cmd <= REFRESH;
                        count    <= COUNT_WIDTH'(T_RFC - 1);
                        state    <= S_INIT_REFRESH;
                    end
                end
                S_INIT_REFRESH: begin
                    if (count == '0) begin
                        if (!second_refresh) begin
                            pins.cmd       <= REFRESH;
                            count          <= COUNT_WIDTH'(T_RFC - 1);
                            second_refresh <= 1'b1;
                        end else begin
                            pins.cmd     <= LOAD_MODE;
                            pins.address <= MODE_REG;
                            pins.ba      <= 2'b00;
                            count        <= COUNT_WIDTH'(T_MRD - 1);
                            state        <= S_INIT_MODE;
                        end
                    end
                end
                S_INIT_MODE: begin
                    if (count == '0)
                        state <= S_IDLE;
                end
                S_IDLE: begin
                    if (refresh_request) begin
                        pins.cmd <= REFRESH;
                        count    <= COUNT_WIDTH'(T_RFC - 1);
                        state    <= S_REFRESH;
                    end else if (read_request || write_request) begin
                        pins.cmd     <= ACTIVE;
                        pins.ba      <= access_addr.field.bank;
                        pins.address <= {1'b0, access_addr.field.row};
                        write_cycle  <= write_request;
                        count        <= COUNT_WIDTH'(T_RCD - 1);
                        state        <= S_ACTIVATE;
                    end
                end
                S_REFRESH: begin
                    if (count == '0)
                        state <= S_IDLE;
                end
                S_ACTIVATE: begin
                    if (count == '0) begin
                        // Column with A10 set for auto-precharge
                        pins.address <= {2'b00, 1'b1, 3'b000, access_addr.field.column};
                        if (write_cycle) begin
                            pins.cmd    <= WRITE;
                            pins.dq_out <= {write_data, write_data};
                            pins.dq_oe  <= 1'b1;
                            // Mask the lane that is not written
                            pins.dqm    <= access_addr.field.lane ? 2'b01 : 2'b10;
                            state       <= S_WRITE;
                        end else begin
                            pins.cmd <= READ;
                            pins.dqm <= 2'b00;
                            count    <= COUNT_WIDTH'(CAS_LATENCY);
                            state    <= S_READ;
                        end
                    end
                end
                S_READ: begin
                    if (count == '0) begin
                        done  <= 1'b1;
                        count <= COUNT_WIDTH'(T_RP);
                        state <= S_RECOVER;
                    end
                end
                S_WRITE: begin
                    done  <= 1'b1;
                    count <= COUNT_WIDTH'(T_RP);
                    state <= S_RECOVER;
                end
                S_RECOVER: begin
                    // Auto-precharge still running in the device
                    if (count == '0)
                        state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Data is on dq_in CAS_LATENCY cycles after the READ command
    always_ff @(posedge clock) begin
        if (state == S_READ && count == '0)
            read_data <= dq_in;
    end

endmodule

//--- hdl/sdram_pkg.sv
// ---------------------------------------------------------------------
// SDRAM device description: command encodings, timing counts in clock
// cycles, the address split of a physical byte address and the pin
// bundle that the controller drives
// ---------------------------------------------------------------------
package sdram_pkg;

    // {cs_n, ras_n, cas_n, we_n}
    typedef enum logic [3:0] {
        LOAD_MODE = 4'b0000,
        REFRESH   = 4'b0001,
        PRECHARGE = 4'b0010,
        ACTIVE    = 4'b0011,
        WRITE     = 4'b0100,
        READ      = 4'b0101,
        NOP       = 4'b0111
    } sdram_cmd_t;

    localparam int INIT_WAIT_CYCLES = 200;
    localparam int T_RP             = 2;
    localparam int T_RFC            = 7;
    localparam int T_RCD            = 2;
    localparam int T_MRD            = 2;
    localparam int CAS_LATENCY      = 2;
    localparam int COUNT_WIDTH      = $clog2(INIT_WAIT_CYCLES + 1);

    // Single-word bursts, sequential order
    localparam logic [12:0] MODE_REG = {6'b000000, 3'(CAS_LATENCY), 4'b0000};

    typedef union packed {
        xt_mem_pkg::phys_addr_t linear;
        struct packed {
            logic [1:0]  bank;
            logic [11:0] row;
            logic [6:0]  column;
            logic        lane;
        } field;
    } sdram_addr_u;

    typedef struct packed {
        logic [12:0] address;
        logic [1:0]  ba;
        logic        cke;
        sdram_cmd_t  cmd;
        logic [15:0] dq_out;
        logic        dq_oe;
        logic [1:0]  dqm;
    } sdram_pins_t;

endpackage

//--- hdl/xt_mem_pkg.sv
// ---------------------------------------------------------------------
// CPU-side view of the XT memory subsystem: bus command, EMS page map,
// BIOS controls and the segment codes used by the address decode
// ---------------------------------------------------------------------
package xt_mem_pkg;

    localparam int EMS_WINDOWS   = 4;
    localparam int EMS_PAGE_BITS = 7;

    // Upper address nibble of a 64 KB segment
    localparam logic [3:0] SEG_A000 = 4'hA;
    localparam logic [3:0] SEG_B000 = 4'hB;
    localparam logic [3:0] SEG_F000 = 4'hF;

    // 16 KB block EC000h-EFFFFh, address bits 19:14
    localparam logic [5:0] BLOCK_EC000 = 6'h3B;

    typedef logic [19:0] bus_addr_t;
    typedef logic [21:0] phys_addr_t;

    typedef struct packed {
        bus_addr_t  address;
        logic [7:0] write_data;
        logic       read_n;
        logic       write_n;
    } bus_cmd_t;

    // Window enables come from the bus-side window decode
    typedef struct packed {
        logic [EMS_WINDOWS-1:0][EMS_PAGE_BITS-1:0] page;
        logic [EMS_WINDOWS-1:0]                    enable;
    } ems_map_t;

    typedef struct packed {
        logic [1:0] protect;
        logic       tandy;
        logic       enable_a000h;
    } bios_ctrl_t;

endpackage

//--- hdl/xt_ram_top.sv
`timescale 1ns/1ps
// ---------------------------------------------------------------------
// XT memory subsystem top: address map, bus port and SDRAM controller
// in a chain between the CPU-side bus and the SDRAM pins
// ---------------------------------------------------------------------
module xt_ram_top (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   enable_sdram,
    input  xt_mem_pkg::bus_cmd_t   cmd,
    input  xt_mem_pkg::ems_map_t   ems,
    input  xt_mem_pkg::bios_ctrl_t bios,
    input  logic                   no_command_state,
    input  logic [15:0]            sdram_dq_in,
    output logic [7:0]             data_bus_out,
    output logic                   memory_access_ready,
    output logic                   ram_address_select_n,
    output logic                   initialized_sdram,
    output sdram_pkg::sdram_pins_t sdram_pins
);
    import sdram_pkg::*;

    sdram_addr_u phys;
    sdram_addr_u access_addr;
    logic        write_protect;
    logic        write_request;
    logic        read_request;
    logic        refresh_request;
    logic        done;
    logic        idle;
    logic [7:0]  write_data;
    logic [15:0] read_data;

    ems_address_map u_address_map (
        .bus_addr      (cmd.address),
        .ems           (ems),
        .bios          (bios),
        .enable_sdram  (enable_sdram),
        .ram_select_n  (ram_address_select_n),
        .write_protect (write_protect),
        .phys          (phys)
    );

    ram_bus_port u_bus_port (
        .clock            (clock),
        .reset            (reset),
        .cmd              (cmd),
        .ram_select_n     (ram_address_select_n),
        .write_protect    (write_protect),
        .phys             (phys),
        .no_command_state (no_command_state),
        .done             (done),
        .idle             (idle),
        .read_data        (read_data),
        .write_request    (write_request),
        .read_request     (read_request),
        .refresh_request  (refresh_request),
        .access_addr      (access_addr),
        .write_data       (write_data),
        .data_bus_out     (data_bus_out),
        .ready            (memory_access_ready),
        .initialized      (initialized_sdram)
    );

    sdram_controller u_sdram_controller (
        .clock           (clock),
        .reset           (reset),
        .write_request   (write_request),
        .read_request    (read_request),
        .refresh_request (refresh_request),
        .access_addr     (access_addr),
        .write_data      (write_data),
        .dq_in           (sdram_dq_in),
        .read_data       (read_data),
        .done            (done),
        .idle            (idle),
        .pins            (sdram_pins)
    );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the XT memory testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --top-module tb_xt_ram -f build.f -Mdir "$OBJ" -o tb_xt_ram
if [ $? -ne 0 ]; then
    echo "Compilation failed"
    exit 1
fi

"./$OBJ/tb_xt_ram" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Verification failed" "$LOG"; then
    exit 1
fi
exit 0

//--- verif/sdram_model.sv
`timescale 1ns/1ps
// ---------------------------------------------------------------------
// Behavioral 16-bit SDRAM for simulation. Decodes the command pins,
// keeps one open row per bank and returns read data with CAS latency 2
// ---------------------------------------------------------------------
module sdram_model (
    input  logic                   clock,
    input  sdram_pkg::sdram_pins_t pins,
    output logic [15:0]            dq
);
    import sdram_pkg::*;

    logic [15:0] mem [int];
    logic [11:0] open_row [4];
    logic [15:0] read_stage;
    logic [20:0] word_index;

    // Word address is bank, open row, column
    assign word_index = {pins.ba, open_row[pins.ba], pins.address[6:0]};

    initial begin
        dq         = 16'h0000;
        read_stage = 16'h0000;
    end

    always @(posedge clock) begin
        logic [15:0] stored;

        // Words never written read back as zero
        stored = mem.exists(int'(word_index)) ? mem[int'(word_index)] : 16'h0000;

        // Two register stages give the CAS latency
        dq         <= read_stage;
        read_stage <= 16'h0000;

        if (pins.cke) begin
            case (pins.cmd)
                ACTIVE: begin
                    open_row[pins.ba] <= pins.address[11:0];
                end
                READ: begin
                    read_stage <= stored;
                end
                WRITE: begin
                    if (pins.dq_oe) begin
                        // dqm high masks a byte lane
                        if (!pins.dqm[0])
                            stored[7:0] = pins.dq_out[7:0];
                        if (!pins.dqm[1])
                            stored[15:8] = pins.dq_out[15:8];
                        mem[int'(word_index)] = stored;
                    end
                end
                default: begin
                end
            endcase
        end
    end

endmodule

//--- verif/tb_xt_ram.sv
`timescale 1ns/1ps
// ---------------------------------------------------------------------
// Testbench for the XT memory subsystem. Drives held CPU bus commands
// into the top level with an SDRAM model attached and checks each read
// against a reference byte store built from the address-map rules
// ---------------------------------------------------------------------
module tb_xt_ram;
    import xt_mem_pkg::*;
    import sdram_pkg::*;

    // Bus accesses over all tests, probes of unmapped segments included
    localparam int NUM_ACCESSES = 230;
    localparam int MAX_CYCLES   = 4 * (INIT_WAIT_CYCLES + NUM_ACCESSES * 20);

    logic        clock = 1'b0;
    logic        reset;
    logic        enable_sdram;
    bus_cmd_t    cmd;
    ems_map_t    ems;
    bios_ctrl_t  bios;
    logic        no_command_state;
    logic [15:0] sdram_dq_in;
    logic [7:0]  data_bus_out;
    logic        memory_access_ready;
    logic        ram_address_select_n;
    logic        initialized_sdram;
    sdram_pins_t sdram_pins;

    logic [7:0] ref_mem [int];
    bus_addr_t  conv_addr [6] = '{20'h00000, 20'h00001, 20'h12345,
                                  20'h9FFFE, 20'hC0001, 20'hEBFFF};
    int         error_count = 0;
    int         check_count = 0;
    int         cycle_count = 0;
    integer     seed = 55;

    always #50 clock = ~clock;

    xt_ram_top UUT (
        .clock                (clock),
        .reset                (reset),
        .enable_sdram         (enable_sdram),
        .cmd                  (cmd),
        .ems                  (ems),
        .bios                 (bios),
        .no_command_state     (no_command_state),
        .sdram_dq_in          (sdram_dq_in),
        .data_bus_out         (data_bus_out),
        .memory_access_ready  (memory_access_ready),
        .ram_address_select_n (ram_address_select_n),
        .initialized_sdram    (initialized_sdram),
        .sdram_pins           (sdram_pins)
    );

    sdram_model u_sdram (
        .clock (clock),
        .pins  (sdram_pins),
        .dq    (sdram_dq_in)
    );

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d clock cycles", MAX_CYCLES);
            $display("Verification failed");
            $finish;
        end
    end

    // Lowest enabled window wins, else conventional with the Tandy bit
    function automatic phys_addr_t expected_phys(input bus_addr_t addr, input ems_map_t map,
                                                 input bios_ctrl_t ctrl);
        for (int i = 0; i < EMS_WINDOWS; i++) begin
            if (map.enable[i])
                return {1'b1, map.page[i], addr[13:0]};
        end
        return {1'b0, ctrl.tandy && (addr[19:16] == 4'hF), addr};
    endfunction

    function automatic logic is_ram(input bus_addr_t addr);
        return (addr[19:16] != 4'hB) && !((addr[19:16] == 4'hA) && !bios.enable_a000h);
    endfunction

    function automatic logic is_protected(input bus_addr_t addr);
        return (bios.protect[1] && addr[19:16] == 4'hF)
            || (bios.protect[0] && addr[19:14] == 6'h3B);
    endfunction

    function automatic logic [7:0] expected_byte(input bus_addr_t addr);
        int key;

        key = int'(expected_phys(addr, ems, bios));
        if (!is_ram(addr) || !ref_mem.exists(key))
            return 8'h00;
        return ref_mem[key];
    endfunction

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, expected);
        end
    endtask

    task automatic bus_access(input logic write, input bus_addr_t addr,
                              input logic [7:0] wdata, output logic [7:0] rdata);
        @(posedge clock);
        #5;
        cmd = '{address: addr, write_data: wdata, read_n: write, write_n: !write};
        @(negedge clock);
        while (!memory_access_ready) begin
            @(negedge clock);
        end
        if (!initialized_sdram && !ram_address_select_n) begin
            error_count++;
            $display("Ready went high for a RAM command before the SDRAM was initialized");
        end
        rdata = data_bus_out;
        @(posedge clock);
        #5;
        cmd = '{address: 20'h0, write_data: 8'h00, read_n: 1'b1, write_n: 1'b1};
    endtask

    task automatic write_byte(input bus_addr_t addr, input logic [7:0] data);
        logic [7:0] unused;

        bus_access(1'b1, addr, data, unused);
        if (is_ram(addr) && !is_protected(addr))
            ref_mem[int'(expected_phys(addr, ems, bios))] = data;
    endtask

    task automatic read_check(input bus_addr_t addr);
        logic [7:0] got;

        bus_access(1'b0, addr, 8'h00, got);
        check_value("data_bus_out", 16'(got), 16'(expected_byte(addr)));
    endtask

    // Unmapped segment answers at once and returns nothing
    task automatic probe_unmapped(input bus_addr_t addr);
        @(posedge clock);
        #5;
        cmd = '{address: addr, write_data: 8'hFF, read_n: 1'b0, write_n: 1'b1};
        @(negedge clock);
        check_value("ram_address_select_n", 16'(ram_address_select_n), 16'h0001);
        check_value("memory_access_ready", 16'(memory_access_ready), 16'h0001);
        check_value("data_bus_out", 16'(data_bus_out), 16'h0000);
        @(posedge clock);
        #5;
        cmd = '{address: 20'h0, write_data: 8'h00, read_n: 1'b1, write_n: 1'b1};
    endtask

    task automatic pulse_no_command();
        @(posedge clock);
        #5;
        no_command_state = 1'b1;
        @(posedge clock);
        #5;
        no_command_state = 1'b0;
    endtask

    task automatic test_done(input string name, input int errors_before);
        $display("Test %s: %s", name, (error_count == errors_before) ? "ok" : "FAILED");
    endtask

    initial begin
        int          mark;
        logic [31:0] pick;
        bus_addr_t   addr;

        reset            = 1'b1;
        enable_sdram     = 1'b1;
        cmd              = '{address: 20'h0, write_data: 8'h00, read_n: 1'b1, write_n: 1'b1};
        ems              = '0;
        bios             = '0;
        no_command_state = 1'b0;
        repeat (3) @(posedge clock);
        #5;
        reset = 1'b0;

        // First command is held behind the power-up sequence
        mark = error_count;
        read_check(20'h00100);
        check_value("initialized_sdram", 16'(initialized_sdram), 16'h0001);
        test_done("initialization", mark);

        mark = error_count;
        for (int i = 0; i < 6; i++) begin
            write_byte(conv_addr[i], 8'(i * 37 + 27));
        end
        for (int i = 0; i < 6; i++) begin
            read_check(conv_addr[i]);
        end
        test_done("conventional memory", mark);

        mark = error_count;
        write_byte(20'hD0123, 8'h6C);
        ems.page[0] = 7'h25;
        ems.enable  = 4'b0001;
        write_byte(20'hD0123, 8'hE5);
        // Window 2 at D8000h, same page and offset
        ems.page[2] = 7'h25;
        ems.enable  = 4'b0100;
        read_check(20'hD8123);
        ems.enable = 4'b0000;
        read_check(20'hD0123);
        test_done("EMS windows", mark);

        mark = error_count;
        write_byte(20'hF0010, 8'hA1);
        write_byte(20'hEC020, 8'hB2);
        bios.protect = 2'b11;
        write_byte(20'hF0010, 8'h5E);
        write_byte(20'hEC020, 8'h4D);
        read_check(20'hF0010);
        read_check(20'hEC020);
        bios.protect = 2'b00;
        bios.tandy   = 1'b1;
        write_byte(20'hF0010, 8'h7A);
        read_check(20'hF0010);
        bios.tandy = 1'b0;
        read_check(20'hF0010);
        test_done("BIOS protect and Tandy remap", mark);

        mark = error_count;
        probe_unmapped(20'hB0040);
        probe_unmapped(20'hA0040);
        bios.enable_a000h = 1'b1;
        write_byte(20'hA0040, 8'hC3);
        read_check(20'hA0040);
        bios.enable_a000h = 1'b0;
        test_done("segment decode", mark);

        // Small address pool so reads hit earlier writes
        mark        = error_count;
        ems.page[1] = 7'h11;
        for (int n = 0; n < 200; n++) begin
            pick       = $random(seed);
            addr       = {(pick[5:4] == 2'd3) ? 4'hC : {2'b00, pick[5:4]}, 12'h123, pick[3:0]};
            ems.enable = {2'b00, pick[6], 1'b0};
            if (pick[7])
                write_byte(addr, pick[15:8]);
            else
                read_check(addr);
            pulse_no_command();
        end
        test_done("mixed traffic", mark);

        $display("Checks: %0d, errors: %0d, cycles: %0d", check_count, error_count, cycle_count);
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
